// File: Bender.yml
package:
  name: writeback

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/wb_pkg.sv
      - rtl/wb_flags_reg.sv
      - rtl/wb_branch_cond.sv
      - rtl/wb_operand_select.sv
      - rtl/wb_commit_gate.sv
      - rtl/writeback.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/writeback_checker.sv
      - sim/writeback_tb.sv

// File: build.f
+incdir+rtl
rtl/wb_pkg.sv
rtl/wb_flags_reg.sv
rtl/wb_branch_cond.sv
rtl/wb_operand_select.sv
rtl/wb_commit_gate.sv
rtl/writeback.sv
sim/writeback_checker.sv
sim/writeback_tb.sv

// File: rtl/wb_branch_cond.sv
`timescale 1ns/1ns
`include "wb_cfg.svh"

module wb_branch_cond
   import wb_pkg::*;
(
   input  wb_ctrl_t              ctrl,
   input  logic [`WB_DATA_W-1:0] final_flags,
   output logic                  branch_taken_raw,
   output logic                  cmov_ok
);

   logic cf;
   logic zf;

   assign cf = final_flags[`WB_CF_BIT];
   assign zf = final_flags[`WB_ZF_BIT];

   always_comb begin
      if (ctrl.is_jne) begin
         branch_taken_raw = ~zf;
      end else if (ctrl.is_jnbe) begin
         // above, unsigned
         branch_taken_raw = ~cf & ~zf;
      end else begin
         branch_taken_raw = 1'b0;
      end
   end

   // only cmovc is conditional on the gpr2 write
   assign cmov_ok = ctrl.is_cmovc ? cf : 1'b1;

endmodule

// File: rtl/wb_cfg.svh
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// datapath widths
`define WB_ADDR_W 32
`define WB_DATA_W 32
`define WB_MM_W 64
`define WB_SEG_W 16

// register number and operand size fields
`define WB_DR_W 3
`define WB_DS_W 2
`define WB_DS_DWORD 2'b10

// reserved bit 1 reads as one
`define WB_FLAGS_RESET 32'h0000_0002

`define WB_CF_BIT 0
`define WB_ZF_BIT 6

`endif

// File: rtl/wb_commit_gate.sv
`timescale 1ns/1ns
`include "wb_cfg.svh"

module wb_commit_gate
   import wb_pkg::*;
(
   input  wb_ctrl_t              ctrl,
   input  wb_uop_t               uop,
   input  logic [`WB_DATA_W-1:0] final_flags,
   input  logic                  cmov_ok,
   input  logic                  write_ready,
   output wb_dep_t               dep,
   output logic                  ld_eip,
   output logic                  ld_cs,
   output logic                  ld_flags,
   output logic [`WB_DR_W-1:0]   dr1_final,
   output logic [`WB_DR_W-1:0]   dr2_final,
   output logic                  commit_en,
   output logic                  halt,
   output logic                  terminate,
   output logic                  stall
);

   logic store_req;
   logic zf;
   logic count_zero;

   assign store_req = uop.v & uop.dcache_write_req;

   // hold the uop until the cache takes the store
   assign stall     = store_req & ~write_ready;
   assign commit_en = uop.v & ~stall;

   assign zf         = final_flags[`WB_ZF_BIT];
   assign count_zero = (uop.result_c == '0);

   // repne cmps stops on a match or an exhausted count
   assign terminate = uop.v & ctrl.is_cmps_second & uop.repne & (zf | count_zero);
   assign halt      = uop.v & ctrl.is_halt;

   always_comb begin
      dep.ld_gpr1      = commit_en & uop.ld_gpr1_req;
      dep.ld_gpr2      = commit_en & uop.ld_gpr2_req & cmov_ok;
      dep.ld_gpr3      = commit_en & ctrl.ld_gpr3 & ~terminate;
      dep.ld_seg       = commit_en & ctrl.ld_seg;
      dep.ld_mm        = commit_en & uop.ld_mm_req;
      // the store itself stays up while stalled
      dep.dcache_write = store_req;
   end

   assign ld_eip   = commit_en & ctrl.ld_eip;
   assign ld_cs    = commit_en & ctrl.ld_cs;
   assign ld_flags = commit_en & ctrl.ld_flags;

   // second cmps uop writes back the string pointers
   always_comb begin
      if (ctrl.is_cmps_second) begin
         dr1_final = ctrl.dr1_d2;
         dr2_final = ctrl.dr2_d2;
      end else begin
         dr1_final = uop.dr1;
         dr2_final = uop.dr2;
      end
   end

endmodule

// File: rtl/wb_flags_reg.sv
`timescale 1ns/1ns
`include "wb_cfg.svh"

module wb_flags_reg
   import wb_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  wb_ctrl_t              ctrl,
   input  logic [`WB_DATA_W-1:0] ex_flags,
   input  logic [`WB_DATA_W-1:0] result_a,
   input  logic                  commit_en,
   output logic [`WB_DATA_W-1:0] final_flags
);

   logic [`WB_DATA_W-1:0] flags_q;
   logic [`WB_DATA_W-1:0] merged;

   // execute flags only in the bits the op affects
   assign merged = (ex_flags & ctrl.flags_affected) |
                   (flags_q & ~ctrl.flags_affected);

   always_comb begin
      if (!ctrl.ld_flags) begin
         final_flags = flags_q;
      end else if (ctrl.pop_flags) begin
         // popf takes the whole word from the stack
         final_flags = result_a;
      end else begin
         final_flags = merged;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         flags_q <= `WB_FLAGS_RESET;
      end else if (commit_en && ctrl.ld_flags) begin
         flags_q <= final_flags;
      end
   end

endmodule

// File: rtl/wb_operand_select.sv
`timescale 1ns/1ns
`include "wb_cfg.svh"

module wb_operand_select
   import wb_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  wb_ctrl_t              ctrl,
   input  wb_uop_t               uop,
   input  logic [`WB_DATA_W-1:0] final_flags,
   input  logic                  branch_taken_raw,
   input  logic                  terminate,
   input  logic                  commit_en,
   output logic [`WB_DATA_W-1:0] data1,
   output logic [`WB_ADDR_W-1:0] eip,
   output logic [`WB_SEG_W-1:0]  cs,
   output logic [`WB_DATA_W-1:0] count
);

   logic [`WB_ADDR_W-1:0] temp_neip;
   logic [`WB_SEG_W-1:0]  temp_ncs;
   logic                  is_branch;
   logic                  take_neip;

   assign is_branch = ctrl.is_jne | ctrl.is_jnbe;

   // fall through to neip unless a branch misses or repne ends
   assign take_neip = branch_taken_raw | (~is_branch & ~terminate);

   always_comb begin
      if (ctrl.push_flags) begin
         data1 = final_flags;
      end else if (ctrl.save_neip) begin
         data1 = temp_neip;
      end else begin
         data1 = uop.result_a;
      end
   end

   always_comb begin
      if (ctrl.use_temp_neip) begin
         eip = temp_neip;
      end else if (take_neip) begin
         eip = uop.neip;
      end else begin
         eip = uop.neip_not_taken;
      end
   end

   assign cs = ctrl.use_temp_ncs ? temp_ncs : uop.ncs;

   // far call return point and the cmps count
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         temp_neip <= '0;
         temp_ncs  <= '0;
         count     <= '0;
      end else if (commit_en) begin
         if (ctrl.save_neip) begin
            temp_neip <= uop.neip;
         end
         if (ctrl.save_ncs) begin
            temp_ncs <= uop.ncs;
         end
         if (ctrl.is_cmps_first) begin
            count <= uop.result_c;
         end
      end
   end

endmodule

// File: rtl/wb_pkg.sv
`include "wb_cfg.svh"

package wb_pkg;

   typedef struct packed {
      logic                  ld_gpr3;
      logic                  ld_seg;
      logic                  ld_flags;
      logic                  ld_eip;
      logic                  ld_cs;
      logic                  pop_flags;
      logic [`WB_DATA_W-1:0] flags_affected;
      logic                  push_flags;
      logic                  save_neip;
      logic                  save_ncs;
      logic                  use_temp_neip;
      logic                  use_temp_ncs;
      logic                  is_jne;
      logic                  is_jnbe;
      logic                  is_cmovc;
      logic                  is_halt;
      logic                  is_cmps_first;
      logic                  is_cmps_second;
      logic                  mm_mem;
      logic [`WB_DR_W-1:0]   dr1_d2;
      logic [`WB_DR_W-1:0]   dr2_d2;
      logic [`WB_DR_W-1:0]   dr3;
   } wb_ctrl_t;

   typedef struct packed {
      logic                  v;
      logic [`WB_DS_W-1:0]   datasize;
      logic                  ld_gpr1_req;
      logic                  ld_gpr2_req;
      logic                  ld_mm_req;
      logic                  dcache_write_req;
      logic                  repne;
      logic [`WB_DATA_W-1:0] result_a;
      logic [`WB_DATA_W-1:0] result_b;
      logic [`WB_DATA_W-1:0] result_c;
      logic [`WB_MM_W-1:0]   result_mm;
      logic [`WB_DATA_W-1:0] ex_flags;
      logic [`WB_ADDR_W-1:0] neip;
      logic [`WB_ADDR_W-1:0] neip_not_taken;
      logic [`WB_SEG_W-1:0]  ncs;
      logic [`WB_DR_W-1:0]   dr1;
      logic [`WB_DR_W-1:0]   dr2;
      logic [`WB_ADDR_W-1:0] address;
   } wb_uop_t;

   typedef struct packed {
      logic [`WB_DR_W-1:0]   dr;
      logic [`WB_DATA_W-1:0] data;
      logic                  ld;
   } gpr_wr_t;

   typedef struct packed {
      gpr_wr_t               gpr1;
      gpr_wr_t               gpr2;
      gpr_wr_t               gpr3;
      logic [`WB_DS_W-1:0]   datasize;
      logic [`WB_DS_W-1:0]   dr3_datasize;
      logic [`WB_MM_W-1:0]   mm_data;
      logic                  ld_mm;
      logic                  ld_seg;
      logic [`WB_ADDR_W-1:0] eip;
      logic                  ld_eip;
      logic [`WB_SEG_W-1:0]  cs;
      logic                  ld_cs;
      logic [`WB_DATA_W-1:0] flags;
      logic                  ld_flags;
   } wb_commit_t;

   // one cache word, either a full mm quadword or a zero padded dword
   typedef union packed {
      logic [`WB_MM_W-1:0] mm;
      struct packed {
         logic [`WB_MM_W-`WB_DATA_W-1:0] pad;
         logic [`WB_DATA_W-1:0]          dword;
      } gpr;
   } dcache_data_u;

   typedef struct packed {
      dcache_data_u          data;
      logic [`WB_ADDR_W-1:0] address;
      logic                  write;
   } dcache_req_t;

   typedef struct packed {
      logic ld_gpr1;
      logic ld_gpr2;
      logic ld_gpr3;
      logic ld_seg;
      logic ld_mm;
      logic dcache_write;
   } wb_dep_t;

endpackage

// File: rtl/writeback.sv
`timescale 1ns/1ns
`include "wb_cfg.svh"

module writeback
   import wb_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  wb_ctrl_t              ctrl,
   input  wb_uop_t               uop,
   input  logic                  write_ready,
   output wb_commit_t            commit,
   output dcache_req_t           store,
   output wb_dep_t               dep,
   output logic                  halt,
   output logic                  repne_terminate,
   output logic                  stall,
   output logic                  branch_taken,
   output logic [`WB_DATA_W-1:0] flags_fwd,
   output logic [`WB_DATA_W-1:0] count_fwd
);

   logic [`WB_DATA_W-1:0] final_flags;
   logic [`WB_DATA_W-1:0] data1;
   logic [`WB_DATA_W-1:0] count;
   logic [`WB_ADDR_W-1:0] eip;
   logic [`WB_SEG_W-1:0]  cs;
   logic [`WB_DR_W-1:0]   dr1_final;
   logic [`WB_DR_W-1:0]   dr2_final;
   logic                  branch_taken_raw;
   logic                  cmov_ok;
   logic                  commit_en;
   logic                  terminate;
   logic                  ld_eip;
   logic                  ld_cs;
   logic                  ld_flags;
   dcache_data_u          store_data;

   wb_flags_reg u_flags_reg (
      .clk         (clk),
      .arst_n      (arst_n),
      .ctrl        (ctrl),
      .ex_flags    (uop.ex_flags),
      .result_a    (uop.result_a),
      .commit_en   (commit_en),
      .final_flags (final_flags)
   );

   wb_branch_cond u_branch_cond (
      .ctrl             (ctrl),
      .final_flags      (final_flags),
      .branch_taken_raw (branch_taken_raw),
      .cmov_ok          (cmov_ok)
   );

   wb_operand_select u_operand_select (
      .clk              (clk),
      .arst_n           (arst_n),
      .ctrl             (ctrl),
      .uop              (uop),
      .final_flags      (final_flags),
      .branch_taken_raw (branch_taken_raw),
      .terminate        (terminate),
      .commit_en        (commit_en),
      .data1            (data1),
      .eip              (eip),
      .cs               (cs),
      .count            (count)
   );

   wb_commit_gate u_commit_gate (
      .ctrl        (ctrl),
      .uop         (uop),
      .final_flags (final_flags),
      .cmov_ok     (cmov_ok),
      .write_ready (write_ready),
      .dep         (dep),
      .ld_eip      (ld_eip),
      .ld_cs       (ld_cs),
      .ld_flags    (ld_flags),
      .dr1_final   (dr1_final),
      .dr2_final   (dr2_final),
      .commit_en   (commit_en),
      .halt        (halt),
      .terminate   (terminate),
      .stall       (stall)
   );

   always_comb begin
      commit.gpr1         = '{dr: dr1_final, data: data1, ld: dep.ld_gpr1};
      commit.gpr2         = '{dr: dr2_final, data: uop.result_b, ld: dep.ld_gpr2};
      commit.gpr3         = '{dr: ctrl.dr3, data: uop.result_c, ld: dep.ld_gpr3};
      commit.datasize     = uop.datasize;
      // gpr3 always takes a full dword
      commit.dr3_datasize = `WB_DS_DWORD;
      commit.mm_data      = uop.result_mm;
      commit.ld_mm        = dep.ld_mm;
      commit.ld_seg       = dep.ld_seg;
      commit.eip          = eip;
      commit.ld_eip       = ld_eip;
      commit.cs           = cs;
      commit.ld_cs        = ld_cs;
      commit.flags        = final_flags;
      commit.ld_flags     = ld_flags;
   end

   // mm stores use the whole word, gpr stores the low dword
   always_comb begin
      if (ctrl.mm_mem) begin
         store_data.mm = uop.result_mm;
      end else begin
         store_data.gpr.pad   = '0;
         store_data.gpr.dword = data1;
      end
   end

   assign store = '{data: store_data, address: uop.address, write: dep.dcache_write};

   assign repne_terminate = terminate;
   assign branch_taken    = uop.v & branch_taken_raw;
   assign flags_fwd       = final_flags;
   assign count_fwd       = count;

endmodule

// File: sim/writeback_checker.sv
`timescale 1ns/1ns
`include "wb_cfg.svh"

module writeback_checker
   import wb_pkg::*;
(
   input logic        clk,
   input logic        arst_n,
   input wb_uop_t     uop,
   input wb_commit_t  commit,
   input dcache_req_t store,
   input wb_dep_t     dep,
   input logic        stall
);

   int assert_fails = 0;

   // an empty slot writes nothing
   a_idle_quiet: assert property (@(posedge clk) disable iff (!arst_n)
      !uop.v |-> (dep == '0) && !commit.gpr1.ld && !commit.gpr2.ld && !commit.gpr3.ld &&
                 !commit.ld_mm && !commit.ld_seg && !commit.ld_eip && !commit.ld_cs &&
                 !commit.ld_flags && !store.write)
      else begin
         assert_fails++;
         $error("a load was raised while the uop was not valid");
      end

   a_stall_no_eip: assert property (@(posedge clk) disable iff (!arst_n)
      stall |-> !commit.ld_eip)
      else begin
         assert_fails++;
         $error("eip was loaded while the stage was stalled");
      end

   a_store_held: assert property (@(posedge clk) disable iff (!arst_n)
      stall ##1 uop.v |-> $stable(store))
      else begin
         assert_fails++;
         $error("the store request changed while it was stalled");
      end

endmodule

// File: sim/writeback_tb.sv
`timescale 1ns/1ns
`include "wb_cfg.svh"

module writeback_tb
   import wb_pkg::*;
();

   localparam int N_ITEMS    = 400;
   localparam int MAX_STALL  = 4;
   localparam int CLK_PERIOD = 20;
   localparam int TIMEOUT_NS = 4 * N_ITEMS * MAX_STALL * CLK_PERIOD;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   typedef logic [`WB_DR_W-1:0]   dr_t;
   typedef logic [`WB_DS_W-1:0]   ds_t;
   typedef logic [`WB_DATA_W-1:0] word_t;
   typedef logic [`WB_ADDR_W-1:0] addr_t;
   typedef logic [`WB_SEG_W-1:0]  seg_t;
   typedef logic [`WB_MM_W-1:0]   mm_t;

   logic        clk;
   logic        arst_n;
   wb_ctrl_t    ctrl;
   wb_uop_t     uop;
   logic        write_ready;
   wb_commit_t  commit;
   dcache_req_t store;
   wb_dep_t     dep;
   logic        halt;
   logic        repne_terminate;
   logic        stall;
   logic        branch_taken;
   word_t       flags_fwd;
   word_t       count_fwd;

   logic [31:0] lfsr;
   wb_ctrl_t    item_ctrl;
   wb_uop_t     item_uop;
   logic        last_stall;

   // reference model state and its value after the next edge
   word_t m_flags;
   addr_t m_temp_neip;
   seg_t  m_temp_ncs;
   word_t m_count;
   word_t nxt_flags;
   addr_t nxt_temp_neip;
   seg_t  nxt_temp_ncs;
   word_t nxt_count;

   int err_commit;
   int err_store;
   int err_dep;
   int err_ctrl;
   int err_word;
   int total_err;

   writeback dut0 (
      .clk             (clk),
      .arst_n          (arst_n),
      .ctrl            (ctrl),
      .uop             (uop),
      .write_ready     (write_ready),
      .commit          (commit),
      .store           (store),
      .dep             (dep),
      .halt            (halt),
      .repne_terminate (repne_terminate),
      .stall           (stall),
      .branch_taken    (branch_taken),
      .flags_fwd       (flags_fwd),
      .count_fwd       (count_fwd)
   );

   bind writeback writeback_checker u_checker (
      .clk    (clk),
      .arst_n (arst_n),
      .uop    (uop),
      .commit (commit),
      .store  (store),
      .dep    (dep),
      .stall  (stall)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // one galois step per bit
   function automatic logic rand_bit();
      logic b;
      b = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? LFSR_TAPS : 32'h0);
      return b;
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[62:0], rand_bit()};
      end
      return r;
   endfunction

   function automatic logic biased_bit();
      logic a;
      logic b;
      a = rand_bit();
      b = rand_bit();
      return a | b;
   endfunction

   task automatic new_item();
      wb_ctrl_t   c;
      wb_uop_t    u;
      logic [1:0] kind;
      logic [1:0] cmps;
      c = '0;
      u = '0;
      kind = 2'(rand_bits(2));
      cmps = 2'(rand_bits(2));
      c.ld_gpr3        = rand_bit();
      c.ld_seg         = rand_bit();
      c.ld_flags       = biased_bit();
      c.ld_eip         = rand_bit();
      c.ld_cs          = rand_bit();
      c.pop_flags      = rand_bit();
      c.flags_affected = word_t'(rand_bits(`WB_DATA_W));
      c.push_flags     = rand_bit();
      c.save_neip      = rand_bit();
      c.save_ncs       = rand_bit();
      c.use_temp_neip  = rand_bit();
      c.use_temp_ncs   = rand_bit();
      c.is_jne         = (kind == 2'd1);
      c.is_jnbe        = (kind == 2'd2);
      c.is_cmovc       = rand_bit();
      c.is_halt        = (2'(rand_bits(2)) == 2'd0);
      c.is_cmps_first  = (cmps == 2'd1);
      c.is_cmps_second = (cmps == 2'd2);
      c.mm_mem         = rand_bit();
      c.dr1_d2         = dr_t'(rand_bits(`WB_DR_W));
      c.dr2_d2         = dr_t'(rand_bits(`WB_DR_W));
      c.dr3            = dr_t'(rand_bits(`WB_DR_W));
      u.v                = biased_bit();
      u.datasize         = ds_t'(rand_bits(`WB_DS_W));
      u.ld_gpr1_req      = biased_bit();
      u.ld_gpr2_req      = biased_bit();
      u.ld_mm_req        = biased_bit();
      u.dcache_write_req = biased_bit();
      u.repne            = biased_bit();
      u.result_a         = word_t'(rand_bits(`WB_DATA_W));
      u.result_b         = word_t'(rand_bits(`WB_DATA_W));
      // a zero count now and then for repne
      if (2'(rand_bits(2)) == 2'd0) begin
         u.result_c = '0;
      end else begin
         u.result_c = word_t'(rand_bits(`WB_DATA_W));
      end
      u.result_mm      = mm_t'(rand_bits(`WB_MM_W));
      u.ex_flags       = word_t'(rand_bits(`WB_DATA_W));
      u.neip           = addr_t'(rand_bits(`WB_ADDR_W));
      u.neip_not_taken = addr_t'(rand_bits(`WB_ADDR_W));
      u.ncs            = seg_t'(rand_bits(`WB_SEG_W));
      u.dr1            = dr_t'(rand_bits(`WB_DR_W));
      u.dr2            = dr_t'(rand_bits(`WB_DR_W));
      u.address        = addr_t'(rand_bits(`WB_ADDR_W));
      item_ctrl = c;
      item_uop  = u;
   endtask

   task automatic check_commit(input string name, input wb_commit_t exp, input wb_commit_t act);
      if (act !== exp) begin
         err_commit++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_store(input string name, input dcache_req_t exp, input dcache_req_t act);
      if (act !== exp) begin
         err_store++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_dep(input string name, input wb_dep_t exp, input wb_dep_t act);
      if (act !== exp) begin
         err_dep++;
         $display("Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_ctrl(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         err_ctrl++;
         $display("Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         err_word++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_outputs(input int item);
      wb_commit_t  e_commit;
      dcache_req_t e_store;
      wb_dep_t     e_dep;
      word_t       ff;
      word_t       data1;
      logic        zf;
      logic        cf;
      logic        taken;
      logic        cmov_ok;
      logic        e_stall;
      logic        ce;
      logic        term;
      logic        go_neip;
      string       tag;
      tag = $sformatf("item %0d", item);
      if (!ctrl.ld_flags) begin
         ff = m_flags;
      end else if (ctrl.pop_flags) begin
         ff = uop.result_a;
      end else begin
         ff = (uop.ex_flags & ctrl.flags_affected) | (m_flags & ~ctrl.flags_affected);
      end
      zf = ff[`WB_ZF_BIT];
      cf = ff[`WB_CF_BIT];
      taken = (ctrl.is_jne && !zf) || (ctrl.is_jnbe && !cf && !zf);
      cmov_ok = ctrl.is_cmovc ? cf : 1'b1;
      e_stall = uop.v && uop.dcache_write_req && !write_ready;
      ce = uop.v && !e_stall;
      term = uop.v && ctrl.is_cmps_second && uop.repne && (zf || uop.result_c == '0);
      e_dep.ld_gpr1      = ce && uop.ld_gpr1_req;
      e_dep.ld_gpr2      = ce && uop.ld_gpr2_req && cmov_ok;
      e_dep.ld_gpr3      = ce && ctrl.ld_gpr3 && !term;
      e_dep.ld_seg       = ce && ctrl.ld_seg;
      e_dep.ld_mm        = ce && uop.ld_mm_req;
      e_dep.dcache_write = uop.v && uop.dcache_write_req;
      if (ctrl.push_flags) begin
         data1 = ff;
      end else if (ctrl.save_neip) begin
         data1 = m_temp_neip;
      end else begin
         data1 = uop.result_a;
      end
      go_neip = taken || (!ctrl.is_jne && !ctrl.is_jnbe && !term);
      e_commit.gpr1.dr   = ctrl.is_cmps_second ? ctrl.dr1_d2 : uop.dr1;
      e_commit.gpr1.data = data1;
      e_commit.gpr1.ld   = e_dep.ld_gpr1;
      e_commit.gpr2.dr   = ctrl.is_cmps_second ? ctrl.dr2_d2 : uop.dr2;
      e_commit.gpr2.data = uop.result_b;
      e_commit.gpr2.ld   = e_dep.ld_gpr2;
      e_commit.gpr3.dr   = ctrl.dr3;
      e_commit.gpr3.data = uop.result_c;
      e_commit.gpr3.ld   = e_dep.ld_gpr3;
      e_commit.datasize     = uop.datasize;
      e_commit.dr3_datasize = `WB_DS_DWORD;
      e_commit.mm_data      = uop.result_mm;
      e_commit.ld_mm        = e_dep.ld_mm;
      e_commit.ld_seg       = e_dep.ld_seg;
      if (ctrl.use_temp_neip) begin
         e_commit.eip = m_temp_neip;
      end else begin
         e_commit.eip = go_neip ? uop.neip : uop.neip_not_taken;
      end
      e_commit.ld_eip   = ce && ctrl.ld_eip;
      e_commit.cs       = ctrl.use_temp_ncs ? m_temp_ncs : uop.ncs;
      e_commit.ld_cs    = ce && ctrl.ld_cs;
      e_commit.flags    = ff;
      e_commit.ld_flags = ce && ctrl.ld_flags;
      if (ctrl.mm_mem) begin
         e_store.data.mm = uop.result_mm;
      end else begin
         e_store.data.mm = {{(`WB_MM_W - `WB_DATA_W){1'b0}}, data1};
      end
      e_store.address = uop.address;
      e_store.write   = e_dep.dcache_write;
      check_commit({tag, " commit"}, e_commit, commit);
      check_store({tag, " store"}, e_store, store);
      check_dep({tag, " dep"}, e_dep, dep);
      check_ctrl({tag, " halt"}, uop.v && ctrl.is_halt, halt);
      check_ctrl({tag, " repne_terminate"}, term, repne_terminate);
      check_ctrl({tag, " stall"}, e_stall, stall);
      check_ctrl({tag, " branch_taken"}, uop.v && taken, branch_taken);
      check_word({tag, " flags_fwd"}, ff, flags_fwd);
      check_word({tag, " count_fwd"}, m_count, count_fwd);
      nxt_flags     = m_flags;
      nxt_temp_neip = m_temp_neip;
      nxt_temp_ncs  = m_temp_ncs;
      nxt_count     = m_count;
      if (ce) begin
         if (ctrl.ld_flags) begin
            nxt_flags = ff;
         end
         if (ctrl.save_neip) begin
            nxt_temp_neip = uop.neip;
         end
         if (ctrl.save_ncs) begin
            nxt_temp_ncs = uop.ncs;
         end
         if (ctrl.is_cmps_first) begin
            nxt_count = uop.result_c;
         end
      end
      // the uop is held for as long as the stage itself stalls
      last_stall = stall;
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog expired before all items were applied");
      $display("test failed");
      $finish;
   end

   initial begin
      int stalls;
      lfsr          = 32'he720;
      arst_n        = 1'b0;
      ctrl          = '0;
      uop           = '0;
      write_ready   = 1'b0;
      err_commit    = 0;
      err_store     = 0;
      err_dep       = 0;
      err_ctrl      = 0;
      err_word      = 0;
      nxt_flags     = `WB_FLAGS_RESET;
      nxt_temp_neip = '0;
      nxt_temp_ncs  = '0;
      nxt_count     = '0;
      repeat (5) @(posedge clk);
      #2 arst_n = 1'b1;
      for (int item = 0; item < N_ITEMS; item++) begin
         new_item();
         stalls = 0;
         last_stall = 1'b1;
         while (last_stall) begin
            @(posedge clk);
            m_flags     = nxt_flags;
            m_temp_neip = nxt_temp_neip;
            m_temp_ncs  = nxt_temp_ncs;
            m_count     = nxt_count;
            #2;
            // held steady while the store waits
            ctrl = item_ctrl;
            uop  = item_uop;
            write_ready = (stalls >= MAX_STALL) ? 1'b1 : rand_bit();
            #8;
            check_outputs(item);
            if (last_stall) begin
               stalls++;
            end
         end
      end
      @(posedge clk);
      total_err = err_commit + err_store + err_dep + err_ctrl + err_word +
                  dut0.u_checker.assert_fails;
      $display("errors: commit %0d, store %0d, dep %0d, ctrl %0d, word %0d, assertion %0d",
               err_commit, err_store, err_dep, err_ctrl, err_word,
               dut0.u_checker.assert_fails);
      if (total_err == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule
